// ==== design/blit_pkg.sv ====
//********************************************************************
// shared types, register numbers and memory sizes of the blitter
// addresses are 16 bits but only the low VRAM_ADDR_W bits reach the
// memory, so higher addresses mirror onto the same words
//********************************************************************

package blit_pkg;

    // data word, used for registers, memory words and bus data
    typedef logic [15:0] word_t;

    // word address as the host programs it
    typedef logic [15:0] addr_t;

    // register number on the host register port
    typedef logic [3:0] reg_num_t;

    // register map, unlisted numbers read as zero
    localparam reg_num_t REG_RD_ADDR = 4'd0;
    localparam reg_num_t REG_WR_ADDR = 4'd1;
    localparam reg_num_t REG_COUNT   = 4'd2;   // write queues a job
    localparam reg_num_t REG_STATUS  = 4'd3;   // read only

    // status word bits
    localparam int STATUS_BUSY_BIT   = 0;
    localparam int STATUS_QUEUED_BIT = 1;

    // memory geometry
    localparam int VRAM_ADDR_W = 8;
    localparam int VRAM_DEPTH  = 1 << VRAM_ADDR_W;

    // idle host cycles spent on each engine access
    localparam int VRAM_WAIT   = 2;
    localparam int VRAM_WAIT_W = $clog2(VRAM_WAIT + 1);

    typedef logic [VRAM_WAIT_W-1:0] wait_cnt_t;

    localparam wait_cnt_t WAIT_FIRE   = wait_cnt_t'(VRAM_WAIT - 1);  // last idle cycle
    localparam wait_cnt_t WAIT_SERVED = wait_cnt_t'(VRAM_WAIT);      // acked, hold

endpackage

// ==== design/blit_regs.sv ====
//********************************************************************
// host register bank of the blitter
// the engine copies the job registers at start, so the host may
// rewrite them during a running job; readback lags one cycle
//********************************************************************

module blit_regs (
    input  logic               clk,
    input  logic               reset_i,
    // host register port
    input  logic               reg_wr_i,
    input  blit_pkg::reg_num_t reg_num_i,
    input  blit_pkg::word_t    reg_data_i,
    output blit_pkg::word_t    reg_data_o,
    // job hand-off to the engine
    input  logic               job_take_i,
    input  logic               busy_i,
    output logic               job_queued_o,
    output blit_pkg::addr_t    rd_addr_o,
    output blit_pkg::addr_t    wr_addr_o,
    output blit_pkg::word_t    count_o
);

    blit_pkg::word_t status;

    always_comb begin
        status                              = '0;
        status[blit_pkg::STATUS_BUSY_BIT]   = busy_i;
        status[blit_pkg::STATUS_QUEUED_BIT] = job_queued_o;
    end

    // register writes and the job queued flag
    always_ff @(posedge clk) begin
        if (reset_i) begin
            rd_addr_o    <= '0;
            wr_addr_o    <= '0;
            count_o      <= '0;
            job_queued_o <= 1'b0;
        end else begin
            if (job_take_i) begin
                job_queued_o <= 1'b0;
            end

            if (reg_wr_i) begin
                case (reg_num_i)
                    blit_pkg::REG_RD_ADDR: begin
                        rd_addr_o <= reg_data_i;
                    end
                    blit_pkg::REG_WR_ADDR: begin
                        wr_addr_o <= reg_data_i;
                    end
                    blit_pkg::REG_COUNT: begin
                        count_o      <= reg_data_i;
                        job_queued_o <= 1'b1;   // beats a take in the same cycle
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // registered readback
    always_ff @(posedge clk) begin
        case (reg_num_i)
            blit_pkg::REG_RD_ADDR: reg_data_o <= rd_addr_o;
            blit_pkg::REG_WR_ADDR: reg_data_o <= wr_addr_o;
            blit_pkg::REG_COUNT:   reg_data_o <= count_o;
            blit_pkg::REG_STATUS:  reg_data_o <= status;
            default:               reg_data_o <= '0;
        endcase
    end

endmodule

// ==== design/blit_engine.sv ====
//********************************************************************
// blitter copy engine, moves count+1 words one at a time
// each word is a read then a write on the select/ack bus, and the
// engine waits for ack without limit
//********************************************************************

module blit_engine (
    input  logic            clk,
    input  logic            reset_i,
    // job from the register bank
    input  logic            job_queued_i,
    input  blit_pkg::addr_t rd_addr_i,
    input  blit_pkg::addr_t wr_addr_i,
    input  blit_pkg::word_t count_i,
    output logic            job_take_o,
    output logic            busy_o,
    output logic            done_o,
    // memory bus
    output logic            mem_sel_o,
    output logic            mem_wr_o,
    output blit_pkg::addr_t mem_addr_o,
    output blit_pkg::word_t mem_wdata_o,
    input  logic            mem_ack_i,
    input  blit_pkg::word_t mem_rdata_i
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_SETUP,
        ST_READ,
        ST_READ_WAIT,
        ST_WRITE,
        ST_WRITE_WAIT,
        ST_DONE
    } blit_state_t;

    blit_state_t     state_q;
    blit_pkg::addr_t rd_addr_q;
    blit_pkg::addr_t wr_addr_q;
    logic [16:0]     remaining_q;     // bit 16 set on underflow

    // take the job in the cycle its values are copied
    assign job_take_o = (state_q == ST_SETUP);

    // no pulse when another job follows directly
    assign done_o = (state_q == ST_DONE) && !job_queued_i;
    assign busy_o = (state_q != ST_IDLE) && !done_o;

    // control
    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q   <= ST_IDLE;
            mem_sel_o <= 1'b0;
            mem_wr_o  <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (job_queued_i) begin
                        state_q <= ST_SETUP;
                    end
                end
                ST_SETUP: begin
                    state_q <= ST_READ;
                end
                ST_READ: begin
                    mem_sel_o <= 1'b1;
                    mem_wr_o  <= 1'b0;
                    state_q   <= ST_READ_WAIT;
                end
                ST_READ_WAIT: begin
                    if (mem_ack_i) begin
                        mem_sel_o <= 1'b0;
                        state_q   <= ST_WRITE;
                    end
                end
                ST_WRITE: begin
                    mem_sel_o <= 1'b1;
                    mem_wr_o  <= 1'b1;
                    state_q   <= ST_WRITE_WAIT;
                end
                ST_WRITE_WAIT: begin
                    if (mem_ack_i) begin
                        mem_sel_o <= 1'b0;
                        if (remaining_q[16]) begin
                            state_q <= ST_DONE;
                        end else begin
                            state_q <= ST_READ;
                        end
                    end
                end
                ST_DONE: begin
                    if (job_queued_i) begin
                        state_q <= ST_SETUP;    // back to back, busy stays up
                    end else begin
                        state_q <= ST_IDLE;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // datapath, addresses and the word in flight
    always_ff @(posedge clk) begin
        case (state_q)
            ST_SETUP: begin
                rd_addr_q   <= rd_addr_i;
                wr_addr_q   <= wr_addr_i;
                remaining_q <= {1'b0, count_i};
            end
            ST_READ: begin
                mem_addr_o <= rd_addr_q;
                rd_addr_q  <= rd_addr_q + 16'd1;
            end
            ST_READ_WAIT: begin
                if (mem_ack_i) begin
                    mem_wdata_o <= mem_rdata_i;   // held until the write is acked
                end
            end
            ST_WRITE: begin
                mem_addr_o  <= wr_addr_q;
                wr_addr_q   <= wr_addr_q + 16'd1;
                remaining_q <= remaining_q - 17'd1;
            end
            default: begin
            end
        endcase
    end

endmodule

// ==== design/vram_store.sv ====
//********************************************************************
// single-port word memory, host port always wins the cycle
// engine accesses complete after VRAM_WAIT host-idle cycles, and the
// wait counter only restarts once the engine drops its select
//********************************************************************

module vram_store (
    input  logic                clk,
    input  logic                reset_i,
    // host port, priority
    input  logic                host_en_i,
    input  logic                host_wr_i,
    input  blit_pkg::addr_t     host_addr_i,
    input  blit_pkg::word_t     host_wdata_i,
    output blit_pkg::word_t     host_rdata_o,
    // engine select/ack bus
    input  logic                mem_sel_i,
    input  logic                mem_wr_i,
    input  blit_pkg::addr_t     mem_addr_i,
    input  blit_pkg::word_t     mem_wdata_i,
    output logic                mem_ack_o,
    output blit_pkg::word_t     mem_rdata_o
);

    blit_pkg::word_t   mem_q [blit_pkg::VRAM_DEPTH];
    blit_pkg::wait_cnt_t wait_cnt_q;
    logic              eng_fire;   // engine access happens this cycle

    assign eng_fire = mem_sel_i && !host_en_i && (wait_cnt_q == blit_pkg::WAIT_FIRE);

    // array, one access per cycle
    always_ff @(posedge clk) begin
        if (host_en_i) begin
            if (host_wr_i) begin
                mem_q[host_addr_i[blit_pkg::VRAM_ADDR_W-1:0]] <= host_wdata_i;
            end else begin
                host_rdata_o <= mem_q[host_addr_i[blit_pkg::VRAM_ADDR_W-1:0]];
            end
        end else if (eng_fire) begin
            if (mem_wr_i) begin
                mem_q[mem_addr_i[blit_pkg::VRAM_ADDR_W-1:0]] <= mem_wdata_i;
            end else begin
                mem_rdata_o <= mem_q[mem_addr_i[blit_pkg::VRAM_ADDR_W-1:0]];
            end
        end
    end

    // wait counter and ack
    always_ff @(posedge clk) begin
        if (reset_i) begin
            wait_cnt_q <= '0;
            mem_ack_o  <= 1'b0;
        end else begin
            mem_ack_o <= eng_fire;
            if (!mem_sel_i) begin
                wait_cnt_q <= '0;
            end else if (eng_fire) begin
                wait_cnt_q <= blit_pkg::WAIT_SERVED;   // no second ack while sel lingers
            end else if (!host_en_i && (wait_cnt_q != blit_pkg::WAIT_SERVED)) begin
                wait_cnt_q <= wait_cnt_q + 1'b1;   // host cycles stall the count
            end
        end
    end

endmodule

// ==== design/blit_top.sv ====
//********************************************************************
// blitter top level, register bank, copy engine and word memory
// host memory port has priority over engine traffic
//********************************************************************

module blit_top (
    input  logic               clk,
    input  logic               reset_i,
    // host register port
    input  logic               reg_wr_i,
    input  blit_pkg::reg_num_t reg_num_i,
    input  blit_pkg::word_t    reg_data_i,
    output blit_pkg::word_t    reg_data_o,
    // host memory port
    input  logic               host_mem_en_i,
    input  logic               host_mem_wr_i,
    input  blit_pkg::addr_t    host_mem_addr_i,
    input  blit_pkg::word_t    host_mem_wdata_i,
    output blit_pkg::word_t    host_mem_rdata_o,
    // status and interrupt
    output logic               blit_busy_o,
    output logic               blit_done_o
);

    // job hand-off
    logic            job_queued;
    logic            job_take;
    blit_pkg::addr_t rd_addr;
    blit_pkg::addr_t wr_addr;
    blit_pkg::word_t count;

    // engine memory bus
    logic            mem_sel;
    logic            mem_wr;
    blit_pkg::addr_t mem_addr;
    blit_pkg::word_t mem_wdata;
    logic            mem_ack;
    blit_pkg::word_t mem_rdata;

    blit_regs i_blit_regs (
        .clk          (clk),
        .reset_i      (reset_i),
        .reg_wr_i     (reg_wr_i),
        .reg_num_i    (reg_num_i),
        .reg_data_i   (reg_data_i),
        .reg_data_o   (reg_data_o),
        .job_take_i   (job_take),
        .busy_i       (blit_busy_o),
        .job_queued_o (job_queued),
        .rd_addr_o    (rd_addr),
        .wr_addr_o    (wr_addr),
        .count_o      (count)
    );

    blit_engine i_blit_engine (
        .clk          (clk),
        .reset_i      (reset_i),
        .job_queued_i (job_queued),
        .rd_addr_i    (rd_addr),
        .wr_addr_i    (wr_addr),
        .count_i      (count),
        .job_take_o   (job_take),
        .busy_o       (blit_busy_o),
        .done_o       (blit_done_o),
        .mem_sel_o    (mem_sel),
        .mem_wr_o     (mem_wr),
        .mem_addr_o   (mem_addr),
        .mem_wdata_o  (mem_wdata),
        .mem_ack_i    (mem_ack),
        .mem_rdata_i  (mem_rdata)
    );

    vram_store i_vram_store (
        .clk          (clk),
        .reset_i      (reset_i),
        .host_en_i    (host_mem_en_i),
        .host_wr_i    (host_mem_wr_i),
        .host_addr_i  (host_mem_addr_i),
        .host_wdata_i (host_mem_wdata_i),
        .host_rdata_o (host_mem_rdata_o),
        .mem_sel_i    (mem_sel),
        .mem_wr_i     (mem_wr),
        .mem_addr_i   (mem_addr),
        .mem_wdata_i  (mem_wdata),
        .mem_ack_o    (mem_ack),
        .mem_rdata_o  (mem_rdata)
    );

endmodule

// ==== bench/blit_tb.sv ====
//**********************************************************************
// testbench for the blitter with a shadow array of the memory
// the shadow array follows host writes and job copies
// copy tests keep source and destination ranges apart
//**********************************************************************

module blit_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT_CYCLES = 20000;   // worst case run is near 6000

    logic               clk;
    logic               reset_i;
    logic               reg_wr_i;
    blit_pkg::reg_num_t reg_num_i;
    blit_pkg::word_t    reg_data_i;
    blit_pkg::word_t    reg_data_o;
    logic               host_mem_en_i;
    logic               host_mem_wr_i;
    blit_pkg::addr_t    host_mem_addr_i;
    blit_pkg::word_t    host_mem_wdata_i;
    blit_pkg::word_t    host_mem_rdata_o;
    logic               blit_busy_o;
    logic               blit_done_o;

    blit_pkg::word_t shadow [blit_pkg::VRAM_DEPTH];   // expected memory contents
    int              cycles = 0;
    int              done_count = 0;

    blit_top i_blit_top (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input blit_pkg::word_t got,
                              input blit_pkg::word_t exp);
        assert (got === exp)
            else fail_run($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
    endtask

    task automatic reg_write(input blit_pkg::reg_num_t num, input blit_pkg::word_t data);
        reg_wr_i   = 1'b1;
        reg_num_i  = num;
        reg_data_i = data;
        @(posedge clk);
        #1;
        reg_wr_i = 1'b0;
    endtask

    task automatic reg_read(input blit_pkg::reg_num_t num, input blit_pkg::word_t exp);
        reg_num_i = num;
        @(posedge clk);
        #1;
        check_word("reg_data_o", reg_data_o, exp);   // one cycle readback
    endtask

    task automatic mem_write(input blit_pkg::addr_t addr, input blit_pkg::word_t data);
        host_mem_en_i    = 1'b1;
        host_mem_wr_i    = 1'b1;
        host_mem_addr_i  = addr;
        host_mem_wdata_i = data;
        shadow[addr % blit_pkg::VRAM_DEPTH] = data;
        @(posedge clk);
        #1;
        host_mem_en_i = 1'b0;
    endtask

    task automatic mem_read(input blit_pkg::addr_t addr);
        host_mem_en_i   = 1'b1;
        host_mem_wr_i   = 1'b0;
        host_mem_addr_i = addr;
        @(posedge clk);
        #1;
        host_mem_en_i = 1'b0;
        check_word("host_mem_rdata_o", host_mem_rdata_o, shadow[addr % blit_pkg::VRAM_DEPTH]);
    endtask

    task automatic check_memory();
        for (int a = 0; a < blit_pkg::VRAM_DEPTH; a++) begin
            mem_read(blit_pkg::addr_t'(a));
        end
    endtask

    task automatic start_job(input blit_pkg::addr_t rd, input blit_pkg::addr_t wr,
                             input blit_pkg::word_t cnt);
        reg_write(blit_pkg::REG_RD_ADDR, rd);
        reg_write(blit_pkg::REG_WR_ADDR, wr);
        reg_write(blit_pkg::REG_COUNT, cnt);
    endtask

    // destination word i takes source word i modulo the depth
    task automatic apply_copy(input int rd, input int wr, input int cnt);
        for (int i = 0; i <= cnt; i++) begin
            shadow[(wr + i) % blit_pkg::VRAM_DEPTH] = shadow[(rd + i) % blit_pkg::VRAM_DEPTH];
        end
    endtask

    // optional host writes into 64..127 and 192..255 while waiting
    task automatic wait_done(input logic traffic);
        @(posedge clk);
        #1;
        while (blit_done_o !== 1'b1) begin
            assert (blit_busy_o === 1'b1)
                else fail_run("busy dropped while a job was still running");
            if (traffic && $urandom_range(0, 1) == 1) begin
                mem_write(blit_pkg::addr_t'(64 + $urandom_range(0, 63)
                                            + 128 * $urandom_range(0, 1)),
                          blit_pkg::word_t'($urandom));
            end else begin
                @(posedge clk);
                #1;
            end
        end
    endtask

    always @(posedge clk) begin
        if (!reset_i && blit_done_o) begin
            done_count <= done_count + 1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            fail_run("timeout, the blitter did not finish within the cycle limit");
        end
    end

    assert property (@(posedge clk) $past(reset_i) |-> !blit_busy_o && !blit_done_o)
        else fail_run("busy or done was high during or right after reset");

    assert property (@(posedge clk) disable iff (reset_i)
        blit_done_o |-> ##1 !blit_done_o)
        else fail_run("done pulse lasted more than one cycle");

    assert property (@(posedge clk) disable iff (reset_i)
        blit_done_o |-> !blit_busy_o && $past(blit_busy_o))
        else fail_run("busy did not fall together with the done pulse");

    assert property (@(posedge clk) disable iff (reset_i)
        reg_wr_i && reg_num_i == blit_pkg::REG_COUNT |-> ##2 blit_busy_o)
        else fail_run("busy was not high two cycles after a count write");

    initial begin
        blit_pkg::word_t a_val;
        blit_pkg::word_t b_val;
        int              src;
        int              dst;
        int              cnt_a;
        int              cnt_b;

        void'($urandom(32'h8704a836));
        reset_i          = 1'b1;
        reg_wr_i         = 1'b0;
        reg_num_i        = '0;
        reg_data_i       = '0;
        host_mem_en_i    = 1'b0;
        host_mem_wr_i    = 1'b0;
        host_mem_addr_i  = '0;
        host_mem_wdata_i = '0;
        repeat (8) @(posedge clk);
        #1;
        reset_i = 1'b0;

        for (int n = 0; n < 5; n++) begin   // number 4 is unmapped
            reg_read(blit_pkg::reg_num_t'(n), '0);
        end

        a_val = blit_pkg::word_t'($urandom);
        b_val = blit_pkg::word_t'($urandom);
        reg_write(blit_pkg::REG_RD_ADDR, a_val);
        reg_write(blit_pkg::REG_WR_ADDR, b_val);
        reg_read(blit_pkg::REG_RD_ADDR, a_val);
        reg_read(blit_pkg::REG_WR_ADDR, b_val);

        for (int a = 0; a < blit_pkg::VRAM_DEPTH; a++) begin
            mem_write(blit_pkg::addr_t'(a), blit_pkg::word_t'($urandom));
        end

        // single copy with the status walking from queued to busy
        src   = $urandom_range(0, 63);
        dst   = 128 + $urandom_range(0, 63);
        cnt_a = $urandom_range(0, 63);
        start_job(src, dst, cnt_a);
        reg_read(blit_pkg::REG_STATUS, 16'h0002);   // queued bit only
        reg_read(blit_pkg::REG_STATUS, 16'h0003);   // busy and still queued
        reg_read(blit_pkg::REG_COUNT, blit_pkg::word_t'(cnt_a));
        wait_done(1'b0);
        apply_copy(src, dst, cnt_a);
        check_memory();
        check_word("done_count", blit_pkg::word_t'(done_count), 16'd1);

        // second job queued behind the first
        cnt_a = $urandom_range(8, 63);
        cnt_b = $urandom_range(0, 63);
        start_job(16'd0, 16'd128, cnt_a);
        repeat (2) begin
            @(posedge clk);
            #1;
        end
        start_job(16'd64, 16'd192, cnt_b);   // first job already snapshotted
        wait_done(1'b0);
        apply_copy(0, 128, cnt_a);
        apply_copy(64, 192, cnt_b);
        check_memory();
        check_word("done_count", blit_pkg::word_t'(done_count), 16'd2);

        // host traffic stretches the engine accesses
        cnt_a = $urandom_range(0, 63);
        start_job(16'd0, 16'd128, cnt_a);
        wait_done(1'b1);
        apply_copy(0, 128, cnt_a);
        check_memory();
        check_word("done_count", blit_pkg::word_t'(done_count), 16'd3);

        // count of zero from a mirrored read address
        src = blit_pkg::VRAM_DEPTH + $urandom_range(0, 63);
        dst = 128 + $urandom_range(0, 63);
        start_job(src, dst, 16'd0);
        wait_done(1'b0);
        apply_copy(src, dst, 0);
        check_memory();
        check_word("done_count", blit_pkg::word_t'(done_count), 16'd4);

        $display("TEST PASS");
        $finish;
    end

endmodule

// ==== tb.f ====
design/blit_pkg.sv
design/blit_regs.sv
design/blit_engine.sv
design/vram_store.sv
design/blit_top.sv
bench/blit_tb.sv

// ==== Bender.yml ====
package:
  name: blit

sources:
  - design/blit_pkg.sv
  - design/blit_regs.sv
  - design/blit_engine.sv
  - design/vram_store.sv
  - design/blit_top.sv
  - target: simulation
    files:
      - bench/blit_tb.sv
